// ==== rtl/dma_pkg.sv ====
// Width constants, vector typedefs and FSM state enums of the copy engine
package dma_pkg;

    // ----------------------------------------------------------
    // Widths
    // ----------------------------------------------------------
    // Word address width, addresses count words and not bytes
    localparam int unsigned AddrWidth  = 16;
    // Data word width
    localparam int unsigned DataWidth  = 32;
    // Transfer length width, counted in words
    localparam int unsigned TfLenWidth = 8;

    // ----------------------------------------------------------
    // Vector types
    // ----------------------------------------------------------
    typedef logic [AddrWidth-1:0]  addr_t;
    typedef logic [DataWidth-1:0]  data_t;
    typedef logic [TfLenWidth-1:0] tf_len_t;

    // ----------------------------------------------------------
    // State machines
    // ----------------------------------------------------------
    // Front end: wait for host, hand out jobs, acknowledge host
    typedef enum logic [1:0] {
        FE_IDLE, FE_DISPATCH, FE_HOST_ACK
    } front_state_e;

    // Write engine: wait for job, write words, respond to host
    typedef enum logic [1:0] {
        WR_IDLE, WR_WRITE, WR_RESPOND, WR_RSP_WAIT
    } wr_state_e;

endpackage

// ==== rtl/dma_word_fifo.sv ====
// Word buffer: circular first-word fall-through FIFO with free-slot count
`timescale 1ns/1ps

module dma_word_fifo #(
    parameter int unsigned BufferDepth = 4
) (
    input  logic                             clk_i,
    input  logic                             arst_n_i,
    input  logic                             push_i,
    input  dma_pkg::data_t                   wdata_i,
    input  logic                             pop_i,
    output dma_pkg::data_t                   rdata_o,
    output logic                             full_o,
    output logic                             empty_o,
    output logic [dma_pkg::TfLenWidth-1:0]   free_o
);

    import dma_pkg::*;

    // Pointer needs at least one bit even for a single entry
    localparam int unsigned PtrWidth = (BufferDepth > 1) ? $clog2(BufferDepth) : 1;
    localparam int unsigned CntWidth = $clog2(BufferDepth + 1);

    data_t                 mem_q [BufferDepth];
    logic [PtrWidth-1:0]   wr_ptr_q, rd_ptr_q;
    logic [CntWidth-1:0]   count_q;
    logic                  do_push, do_pop;

    // Ignore pushes into a full and pops from an empty buffer
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    assign full_o  = (count_q == CntWidth'(BufferDepth));
    assign empty_o = (count_q == '0);
    assign free_o  = TfLenWidth'(BufferDepth - count_q);

    // Head word is visible without a pop
    assign rdata_o = mem_q[rd_ptr_q];

    // ----------------------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // Explicit wrap, depth need not be a power of two
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PtrWidth'(BufferDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PtrWidth'(BufferDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= wdata_i;
        end
    end

endmodule

// ==== rtl/dma_req_frontend.sv ====
// Host request intake, zero-length rejection and dispatch of read and write jobs
`timescale 1ns/1ps

module dma_req_frontend (
    input  logic              clk_i,
    input  logic              arst_n_i,
    // Host request
    input  logic              req_i,
    input  dma_pkg::addr_t    src_addr_i,
    input  dma_pkg::addr_t    dst_addr_i,
    input  dma_pkg::tf_len_t  len_i,
    output logic              ack_o,
    // Read job
    output logic              rd_job_req_o,
    output dma_pkg::addr_t    rd_job_src_o,
    output dma_pkg::tf_len_t  rd_job_len_o,
    input  logic              rd_job_ack_i,
    // Write job
    output logic              wr_job_req_o,
    output dma_pkg::addr_t    wr_job_dst_o,
    output dma_pkg::tf_len_t  wr_job_len_o,
    output logic              wr_job_reject_o,
    input  logic              wr_job_ack_i,
    output logic              busy_o
);

    import dma_pkg::*;

    front_state_e state_q, state_d;

    // Latched request
    addr_t   src_q, dst_q;
    tf_len_t len_q;
    logic    reject_q;

    // Set once the engine has acknowledged its job
    logic    rd_acked_q, wr_acked_q;
    logic    rd_done, wr_done;

    // Job requests stay up until the engine acknowledges
    assign rd_job_req_o = (state_q == FE_DISPATCH) & ~rd_acked_q & ~reject_q;
    assign wr_job_req_o = (state_q == FE_DISPATCH) & ~wr_acked_q;

    // Handshake is complete once the ack has fallen again
    // a rejected transfer never needs a read job
    assign rd_done = reject_q | (rd_acked_q & ~rd_job_ack_i);
    assign wr_done = wr_acked_q & ~wr_job_ack_i;

    assign rd_job_src_o    = src_q;
    assign rd_job_len_o    = len_q;
    assign wr_job_dst_o    = dst_q;
    assign wr_job_len_o    = len_q;
    assign wr_job_reject_o = reject_q;

    assign ack_o  = (state_q == FE_HOST_ACK);
    assign busy_o = (state_q != FE_IDLE);

    // ----------------------------------------------------------
    // Next state
    // ----------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            FE_IDLE: begin
                if (req_i) begin
                    state_d = FE_DISPATCH;
                end
            end
            FE_DISPATCH: begin
                // Both jobs handed over before the host sees ack
                if (rd_done && wr_done) begin
                    state_d = FE_HOST_ACK;
                end
            end
            FE_HOST_ACK: begin
                if (!req_i) begin
                    state_d = FE_IDLE;
                end
            end
            default: state_d = FE_IDLE;
        endcase
    end

    // ----------------------------------------------------------
    // State and handshake flags
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= FE_IDLE;
            rd_acked_q <= 1'b0;
            wr_acked_q <= 1'b0;
            reject_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == FE_IDLE && req_i) begin
                rd_acked_q <= 1'b0;
                wr_acked_q <= 1'b0;
                // Zero-length transfers get an error response only
                reject_q   <= (len_i == '0);
            end
            if (rd_job_req_o && rd_job_ack_i) begin
                rd_acked_q <= 1'b1;
            end
            if (wr_job_req_o && wr_job_ack_i) begin
                wr_acked_q <= 1'b1;
            end
        end
    end

    // Request payload
    always_ff @(posedge clk_i) begin
        if (state_q == FE_IDLE && req_i) begin
            src_q <= src_addr_i;
            dst_q <= dst_addr_i;
            len_q <= len_i;
        end
    end

endmodule

// ==== rtl/dma_read_engine.sv ====
// Read engine: source word reads with buffer back-pressure, returned words go to the buffer
`timescale 1ns/1ps

module dma_read_engine (
    input  logic              clk_i,
    input  logic              arst_n_i,
    // Job from the front end
    input  logic              job_req_i,
    input  dma_pkg::addr_t    job_src_i,
    input  dma_pkg::tf_len_t  job_len_i,
    output logic              job_ack_o,
    // Memory read port
    output logic              rd_req_o,
    output dma_pkg::addr_t    rd_addr_o,
    input  logic              rd_gnt_i,
    input  logic              rd_rvalid_i,
    input  dma_pkg::data_t    rd_rdata_i,
    // Word buffer
    output logic              push_o,
    output dma_pkg::data_t    push_data_o,
    input  dma_pkg::tf_len_t  buf_free_i,
    output logic              busy_o
);

    import dma_pkg::*;

    logic    active_q;
    logic    job_ack_q;
    addr_t   addr_q;
    tf_len_t remaining_q;
    // Granted reads whose data has not come back yet
    tf_len_t outstanding_q;
    logic    job_take, rd_fire;

    // New job only when idle and the last handshake has closed
    assign job_take = job_req_i & ~active_q & ~job_ack_q;
    assign rd_fire  = rd_req_o & rd_gnt_i;

    // Keep a slot free for every read still in flight
    assign rd_req_o  = active_q & (remaining_q != '0) & (buf_free_i > outstanding_q);
    assign rd_addr_o = addr_q;
    assign job_ack_o = job_ack_q;

    // Returned data is pushed as is
    assign push_o      = rd_rvalid_i;
    assign push_data_o = rd_rdata_i;

    assign busy_o = active_q | (outstanding_q != '0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            active_q      <= 1'b0;
            job_ack_q     <= 1'b0;
            addr_q        <= '0;
            remaining_q   <= '0;
            outstanding_q <= '0;
        end else begin
            // ----------------------------------------------------------
            // Job handshake
            // ----------------------------------------------------------
            if (job_take) begin
                active_q    <= 1'b1;
                job_ack_q   <= 1'b1;
                addr_q      <= job_src_i;
                remaining_q <= job_len_i;
            end else if (job_ack_q && !job_req_i) begin
                job_ack_q <= 1'b0;
            end
            // One word per grant; job ends with the last grant
            if (rd_fire) begin
                addr_q      <= addr_q + 1'b1;
                remaining_q <= remaining_q - 1'b1;
                if (remaining_q == tf_len_t'(1)) begin
                    active_q <= 1'b0;
                end
            end
            // In-flight count, data returns one cycle after the grant
            if (rd_fire && !rd_rvalid_i) begin
                outstanding_q <= outstanding_q + 1'b1;
            end else if (rd_rvalid_i && !rd_fire) begin
                outstanding_q <= outstanding_q - 1'b1;
            end
        end
    end

endmodule

// ==== rtl/dma_write_engine.sv ====
// Write engine: buffer pops, destination writes and the host response handshake
`timescale 1ns/1ps

module dma_write_engine (
    input  logic              clk_i,
    input  logic              arst_n_i,
    // Job from the front end
    input  logic              job_req_i,
    input  dma_pkg::addr_t    job_dst_i,
    input  dma_pkg::tf_len_t  job_len_i,
    input  logic              job_reject_i,
    output logic              job_ack_o,
    // Word buffer
    output logic              pop_o,
    input  dma_pkg::data_t    pop_data_i,
    input  logic              buf_empty_i,
    // Memory write port
    output logic              wr_req_o,
    output dma_pkg::addr_t    wr_addr_o,
    output dma_pkg::data_t    wr_wdata_o,
    input  logic              wr_gnt_i,
    // Host response
    output logic              rsp_req_o,
    input  logic              rsp_ack_i,
    output logic              rsp_error_o,
    output logic              busy_o
);

    import dma_pkg::*;

    wr_state_e state_q, state_d;
    logic      job_ack_q;
    logic      error_q;
    addr_t     addr_q;
    tf_len_t   remaining_q;
    logic      job_take, wr_fire;

    assign job_take = job_req_i & (state_q == WR_IDLE) & ~job_ack_q;
    assign wr_fire  = wr_req_o & wr_gnt_i;

    // Head of buffer is the write data, popped on grant
    // only the write engine pops, so the head stays put while waiting
    assign wr_req_o   = (state_q == WR_WRITE) & ~buf_empty_i;
    assign wr_addr_o  = addr_q;
    assign wr_wdata_o = pop_data_i;
    assign pop_o      = wr_fire;

    assign rsp_req_o   = (state_q == WR_RESPOND);
    assign rsp_error_o = error_q;
    assign job_ack_o   = job_ack_q;
    assign busy_o      = (state_q != WR_IDLE);

    // ----------------------------------------------------------
    // Next state
    // ----------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            WR_IDLE: begin
                // Rejected jobs skip straight to the response
                if (job_take) begin
                    state_d = job_reject_i ? WR_RESPOND : WR_WRITE;
                end
            end
            WR_WRITE: begin
                if (wr_fire && remaining_q == tf_len_t'(1)) begin
                    state_d = WR_RESPOND;
                end
            end
            WR_RESPOND: begin
                if (rsp_ack_i) begin
                    state_d = WR_RSP_WAIT;
                end
            end
            WR_RSP_WAIT: begin
                if (!rsp_ack_i) begin
                    state_d = WR_IDLE;
                end
            end
            default: state_d = WR_IDLE;
        endcase
    end

    // ----------------------------------------------------------
    // Registers
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= WR_IDLE;
            job_ack_q   <= 1'b0;
            error_q     <= 1'b0;
            addr_q      <= '0;
            remaining_q <= '0;
        end else begin
            state_q <= state_d;
            if (job_take) begin
                job_ack_q   <= 1'b1;
                error_q     <= job_reject_i;
                addr_q      <= job_dst_i;
                remaining_q <= job_len_i;
            end else if (job_ack_q && !job_req_i) begin
                job_ack_q <= 1'b0;
            end
            // Consecutive destination words
            if (wr_fire) begin
                addr_q      <= addr_q + 1'b1;
                remaining_q <= remaining_q - 1'b1;
            end
        end
    end

endmodule

// ==== rtl/dma_copy_engine.sv ====
// Top level of the copy engine: front end, read engine, word buffer and write engine
`timescale 1ns/1ps

module dma_copy_engine #(
    parameter int unsigned BufferDepth = 4
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    // Host request
    input  logic              req_i,
    input  dma_pkg::addr_t    src_addr_i,
    input  dma_pkg::addr_t    dst_addr_i,
    input  dma_pkg::tf_len_t  len_i,
    output logic              ack_o,
    // Host response
    output logic              rsp_req_o,
    input  logic              rsp_ack_i,
    output logic              rsp_error_o,
    // Memory read port
    output logic              rd_req_o,
    output dma_pkg::addr_t    rd_addr_o,
    input  logic              rd_gnt_i,
    input  logic              rd_rvalid_i,
    input  dma_pkg::data_t    rd_rdata_i,
    // Memory write port
    output logic              wr_req_o,
    output dma_pkg::addr_t    wr_addr_o,
    output dma_pkg::data_t    wr_wdata_o,
    input  logic              wr_gnt_i,
    output logic              busy_o
);

    import dma_pkg::*;

    // Job channels
    logic    rd_job_req, rd_job_ack;
    addr_t   rd_job_src;
    tf_len_t rd_job_len;
    logic    wr_job_req, wr_job_ack, wr_job_reject;
    addr_t   wr_job_dst;
    tf_len_t wr_job_len;

    // Buffer signals
    logic    push, pop, buf_empty;
    data_t   push_data, pop_data;
    tf_len_t buf_free;

    logic    fe_busy, rd_busy, wr_busy;

    // Any stage still working keeps the engine busy
    assign busy_o = fe_busy | rd_busy | wr_busy;

    dma_req_frontend i_frontend (
        .clk_i, .arst_n_i, .req_i, .src_addr_i, .dst_addr_i, .len_i, .ack_o,
        .rd_job_req_o (rd_job_req), .rd_job_src_o (rd_job_src), .rd_job_len_o (rd_job_len),
        .rd_job_ack_i (rd_job_ack), .wr_job_req_o (wr_job_req), .wr_job_dst_o (wr_job_dst),
        .wr_job_len_o (wr_job_len), .wr_job_reject_o (wr_job_reject),
        .wr_job_ack_i (wr_job_ack), .busy_o (fe_busy)
    );

    dma_read_engine i_read_engine (
        .clk_i, .arst_n_i, .job_req_i (rd_job_req), .job_src_i (rd_job_src),
        .job_len_i (rd_job_len), .job_ack_o (rd_job_ack), .rd_req_o, .rd_addr_o, .rd_gnt_i,
        .rd_rvalid_i, .rd_rdata_i, .push_o (push), .push_data_o (push_data),
        .buf_free_i (buf_free), .busy_o (rd_busy)
    );

    dma_word_fifo #(
        .BufferDepth (BufferDepth)
    ) i_word_fifo (
        .clk_i, .arst_n_i, .push_i (push), .wdata_i (push_data), .pop_i (pop),
        .rdata_o (pop_data), .full_o (), .empty_o (buf_empty), .free_o (buf_free)
    );

    dma_write_engine i_write_engine (
        .clk_i, .arst_n_i, .job_req_i (wr_job_req), .job_dst_i (wr_job_dst),
        .job_len_i (wr_job_len), .job_reject_i (wr_job_reject), .job_ack_o (wr_job_ack),
        .pop_o (pop), .pop_data_i (pop_data), .buf_empty_i (buf_empty), .wr_req_o,
        .wr_addr_o, .wr_wdata_o, .wr_gnt_i, .rsp_req_o, .rsp_ack_i, .rsp_error_o,
        .busy_o (wr_busy)
    );

endmodule

// ==== testbench/tb_dma_mem.sv ====
// Behavioral word memory with a read port, a write port and randomly stalled grants
`timescale 1ns/1ps

module tb_dma_mem #(
    parameter int unsigned    MemWords = 65536,
    parameter dma_pkg::data_t FillKey  = '0,
    parameter int unsigned    MaxStall = 3
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    // Read port, data one cycle after the grant
    input  logic              rd_req_i,
    input  dma_pkg::addr_t    rd_addr_i,
    output logic              rd_gnt_o,
    output logic              rd_rvalid_o,
    output dma_pkg::data_t    rd_rdata_o,
    // Write port, the word lands at the grant edge
    input  logic              wr_req_i,
    input  dma_pkg::addr_t    wr_addr_i,
    input  dma_pkg::data_t    wr_wdata_i,
    output logic              wr_gnt_o,
    output int unsigned       wr_count_o
);

    import dma_pkg::*;

    data_t       mem [MemWords];
    int unsigned rd_stall_q, wr_stall_q;
    logic        rd_fire, wr_fire;

    assign rd_fire = rd_req_i & rd_gnt_o;
    assign wr_fire = wr_req_i & wr_gnt_o;

    // Fill word is the full address XOR a key
    initial begin
        for (int i = 0; i < MemWords; i++) begin
            mem[i] = data_t'(i) ^ FillKey;
        end
    end

    // ----------------------------------------------------------
    // Read port
    // ----------------------------------------------------------
    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_gnt_o    <= 1'b0;
            rd_rvalid_o <= 1'b0;
            rd_rdata_o  <= '0;
            rd_stall_q  <= 0;
        end else begin
            rd_rvalid_o <= rd_fire;
            if (rd_fire) begin
                rd_rdata_o <= mem[rd_addr_i];
                rd_gnt_o   <= 1'b0;
                // Fresh random stall for the next access
                rd_stall_q <= $urandom_range(MaxStall, 0);
            end else if (rd_req_i && !rd_gnt_o) begin
                if (rd_stall_q == 0) begin
                    rd_gnt_o <= 1'b1;
                end else begin
                    rd_stall_q <= rd_stall_q - 1;
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Write port
    // ----------------------------------------------------------
    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_gnt_o   <= 1'b0;
            wr_stall_q <= 0;
            wr_count_o <= 0;
        end else begin
            if (wr_fire) begin
                mem[wr_addr_i] <= wr_wdata_i;
                wr_count_o     <= wr_count_o + 1;
                wr_gnt_o       <= 1'b0;
                wr_stall_q     <= $urandom_range(MaxStall, 0);
            end else if (wr_req_i && !wr_gnt_o) begin
                // Count down the stall, then grant
                if (wr_stall_q == 0) begin
                    wr_gnt_o <= 1'b1;
                end else begin
                    wr_stall_q <= wr_stall_q - 1;
                end
            end
        end
    end

endmodule

// ==== testbench/tb_dma_copy_engine.sv ====
// Testbench top: clock, reset, transfer table, host drivers, checks and timeout
`timescale 1ns/1ps

module tb_dma_copy_engine;

    import dma_pkg::*;

    localparam int unsigned BufferDepth   = 4;
    // Memories span the whole word address space
    localparam int unsigned MemWords      = 1 << AddrWidth;
    localparam data_t       SrcKey        = 32'h5A5A_C3C3;
    localparam data_t       DstKey        = 32'h0F0F_A0A0;
    localparam int unsigned CyclesPerWord = 40;

    // ----------------------------------------------------------
    // Transfer table, disjoint destination ranges
    // ----------------------------------------------------------
    localparam int      NumTf = 8;
    localparam addr_t   TfSrc [NumTf] = '{16'h0010, 16'h0020, 16'h0030, 16'h0040,
                                          16'h0005, 16'h0080, 16'h0090, 16'h00F0};
    localparam addr_t   TfDst [NumTf] = '{16'h0000, 16'h0008, 16'h0010, 16'h0018,
                                          16'h0030, 16'h0040, 16'h0048, 16'h0060};
    // Entry 3 is much longer than the buffer
    localparam tf_len_t TfLen [NumTf] = '{8'd3, 8'd1, 8'd0, 8'd20, 8'd7, 8'd0, 8'd12, 8'd16};
    localparam logic    TfErr [NumTf] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

    logic        clk_i, arst_n_i;
    logic        req_i, ack_o, rsp_req_o, rsp_ack_i, rsp_error_o, busy_o;
    addr_t       src_addr_i, dst_addr_i, rd_addr_o, wr_addr_o;
    tf_len_t     len_i;
    logic        rd_req_o, rd_gnt_i, rd_rvalid_i, wr_req_o, wr_gnt_i;
    data_t       rd_rdata_i, wr_wdata_o;
    int unsigned dst_wr_count;
    int unsigned value_errors = 0;
    int unsigned timeouts = 0;
    int unsigned cycle_count = 0;
    int unsigned timeout_limit = 0;
    int unsigned rsp_count = 0;
    logic        rsp_req_q = 1'b0;
    data_t       exp_dst [MemWords];

    dma_copy_engine #(
        .BufferDepth (BufferDepth)
    ) i_dma_copy_engine (
        .clk_i, .arst_n_i, .req_i, .src_addr_i, .dst_addr_i, .len_i, .ack_o,
        .rsp_req_o, .rsp_ack_i, .rsp_error_o, .rd_req_o, .rd_addr_o, .rd_gnt_i,
        .rd_rvalid_i, .rd_rdata_i, .wr_req_o, .wr_addr_o, .wr_wdata_o, .wr_gnt_i, .busy_o
    );

    // Source memory, read port only
    tb_dma_mem #(.MemWords (MemWords), .FillKey (SrcKey), .MaxStall (2)) i_src_mem (
        .clk_i, .arst_n_i, .rd_req_i (rd_req_o), .rd_addr_i (rd_addr_o), .rd_gnt_o (rd_gnt_i),
        .rd_rvalid_o (rd_rvalid_i), .rd_rdata_o (rd_rdata_i), .wr_req_i (1'b0),
        .wr_addr_i ('0), .wr_wdata_i ('0), .wr_gnt_o (), .wr_count_o ()
    );

    // Destination memory with long write stalls, so the buffer fills up
    tb_dma_mem #(.MemWords (MemWords), .FillKey (DstKey), .MaxStall (8)) i_dst_mem (
        .clk_i, .arst_n_i, .rd_req_i (1'b0), .rd_addr_i ('0), .rd_gnt_o (), .rd_rvalid_o (),
        .rd_rdata_o (), .wr_req_i (wr_req_o), .wr_addr_i (wr_addr_o), .wr_wdata_i (wr_wdata_o),
        .wr_gnt_o (wr_gnt_i), .wr_count_o (dst_wr_count)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            value_errors++;
            $display("FAILED at %0d ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, got, expected);
        end
    endtask

    task automatic print_error_counts();
        $display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeouts);
    endtask

    function automatic int unsigned total_len();
        int unsigned sum;
        sum = 0;
        for (int i = 0; i < NumTf; i++) begin
            sum += int'(TfLen[i]);
        end
        return sum;
    endfunction

    // Destination image: fill pattern, then every nonzero copy on top
    task automatic build_expected();
        addr_t a;
        for (int w = 0; w < MemWords; w++) begin
            exp_dst[w] = data_t'(w) ^ DstKey;
        end
        for (int i = 0; i < NumTf; i++) begin
            for (int k = 0; k < int'(TfLen[i]); k++) begin
                a = TfSrc[i] + addr_t'(k);
                exp_dst[TfDst[i] + addr_t'(k)] = data_t'(a) ^ SrcKey;
            end
        end
    endtask

    // Host request side, four-phase per table entry
    task automatic drive_requests();
        for (int i = 0; i < NumTf; i++) begin
            @(posedge clk_i);
            req_i      <= 1'b1;
            src_addr_i <= TfSrc[i];
            dst_addr_i <= TfDst[i];
            len_i      <= TfLen[i];
            @(posedge clk_i);
            while (!ack_o) @(posedge clk_i);
            req_i <= 1'b0;
            @(posedge clk_i);
            while (ack_o) @(posedge clk_i);
        end
    endtask

    // Host response side, runs alongside the requests
    task automatic collect_responses();
        int unsigned prev_count;
        int unsigned delay;
        prev_count = 0;
        for (int i = 0; i < NumTf; i++) begin
            @(posedge clk_i);
            while (!rsp_req_o) @(posedge clk_i);
            check_value($sformatf("rsp_error_o of transfer %0d", i),
                        32'(rsp_error_o), 32'(TfErr[i]));
            // Write engine is serial, so these writes belong to transfer i alone
            check_value($sformatf("destination write count of transfer %0d", i),
                        dst_wr_count - prev_count, 32'(TfLen[i]));
            prev_count = dst_wr_count;
            delay = $urandom_range(5, 0);
            repeat (delay) @(posedge clk_i);
            rsp_ack_i <= 1'b1;
            @(posedge clk_i);
            while (rsp_req_o) @(posedge clk_i);
            rsp_ack_i <= 1'b0;
        end
    endtask

    // Every rising response request counts as one response
    always @(posedge clk_i) begin
        rsp_req_q <= rsp_req_o;
        if (rsp_req_o && !rsp_req_q) begin
            rsp_count <= rsp_count + 1;
        end
    end

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        void'($urandom(2));
        arst_n_i   = 1'b0;
        req_i      = 1'b0;
        src_addr_i = '0;
        dst_addr_i = '0;
        len_i      = '0;
        rsp_ack_i  = 1'b0;
        timeout_limit = CyclesPerWord * total_len() + 500;
        build_expected();
        // First edge applies reset, then outputs must stay quiet
        @(posedge clk_i);
        repeat (15) begin
            @(posedge clk_i);
            check_value("ack_o", 32'(ack_o), 32'd0);
            check_value("rsp_req_o", 32'(rsp_req_o), 32'd0);
            check_value("rd_req_o", 32'(rd_req_o), 32'd0);
            check_value("wr_req_o", 32'(wr_req_o), 32'd0);
            check_value("busy_o", 32'(busy_o), 32'd0);
        end
        arst_n_i <= 1'b1;
        fork
            drive_requests();
            collect_responses();
        join
        // Write engine is back in idle one cycle after rsp_ack_i drops
        repeat (3) @(posedge clk_i);
        check_value("busy_o", 32'(busy_o), 32'd0);
        check_value("rsp_req_o", 32'(rsp_req_o), 32'd0);
        check_value("wr_req_o", 32'(wr_req_o), 32'd0);
        check_value("response count", rsp_count, 32'(NumTf));
        // Copied ranges and untouched words in one pass
        for (int w = 0; w < MemWords; w++) begin
            check_value($sformatf("destination word 0x%04h", w),
                        i_dst_mem.mem[w], exp_dst[w]);
        end
        print_error_counts();
        if (value_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Cycle budget scales with the table
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
            timeouts = 1;
            $display("Timeout after %0d cycles, the transfers did not complete", cycle_count);
            print_error_counts();
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
rtl/dma_pkg.sv
rtl/dma_word_fifo.sv
rtl/dma_req_frontend.sv
rtl/dma_read_engine.sv
rtl/dma_write_engine.sv
rtl/dma_copy_engine.sv
testbench/tb_dma_mem.sv
testbench/tb_dma_copy_engine.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing
TOP      := tb_dma_copy_engine
FILELIST := verilog.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	@./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" $(LOG); then \
		echo "Test run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
